// ==== common/csr_pkg.sv ====
package csr_pkg;

   // CSR address space
   typedef logic [13:0] csr_num_t;

   localparam csr_num_t CSR_CRMD   = 14'h0000;
   localparam csr_num_t CSR_PRMD   = 14'h0001;
   localparam csr_num_t CSR_ECFG   = 14'h0004;
   localparam csr_num_t CSR_ESTAT  = 14'h0005;
   localparam csr_num_t CSR_ERA    = 14'h0006;
   localparam csr_num_t CSR_BADV   = 14'h0007;
   localparam csr_num_t CSR_EENTRY = 14'h000c;
   // SAVEn sits at CSR_SAVE0 + n
   localparam csr_num_t CSR_SAVE0  = 14'h0030;
   localparam csr_num_t CSR_TID    = 14'h0040;
   localparam csr_num_t CSR_TCFG   = 14'h0041;
   localparam csr_num_t CSR_TVAL   = 14'h0042;
   localparam csr_num_t CSR_TICLR  = 14'h0044;

   // Exception cause encodings
   typedef logic [5:0] ecode_t;
   typedef logic [8:0] esubcode_t;

   localparam ecode_t    ECODE_ADE = 6'h08;
   localparam ecode_t    ECODE_ALE = 6'h09;
   localparam esubcode_t ESUB_ADEF = 9'd0;

   // CRMD layout
   typedef struct packed {
      logic [22:0] rsvd;
      logic [1:0]  datm;
      logic [1:0]  datf;
      logic        pg;
      logic        da;
      logic        ie;
      logic [1:0]  plv;
   } crmd_t;

   // PRMD layout
   typedef struct packed {
      logic [28:0] rsvd;
      logic        pie;
      logic [1:0]  pplv;
   } prmd_t;

   // ESTAT layout, bit 31 and 15:13 read as zero
   typedef struct packed {
      logic        rsvd_hi;
      esubcode_t   esubcode;
      ecode_t      ecode;
      logic [2:0]  rsvd_lo;
      logic [12:0] is;
   } estat_t;

   // TCFG layout
   typedef struct packed {
      logic [29:0] initval;
      logic        periodic;
      logic        en;
   } tcfg_t;

   // Merged write word, viewed through the layout of the target register
   typedef union packed {
      logic [31:0] raw;
      crmd_t       crmd;
      prmd_t       prmd;
      estat_t      estat;
      tcfg_t       tcfg;
   } csr_word_t;

   // LIE bit 10 does not exist
   localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;

   // Counter value while stopped
   localparam logic [31:0] TIMER_IDLE = 32'hffff_ffff;

   // Reset value of CRMD, direct address mode
   localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

endpackage

// ==== design/csr_access_ctrl.sv ====
`timescale 1ns/10ps

module csr_access_ctrl import csr_pkg::*; #(
   parameter int NUM_SAVE = 4
) (
   input  csr_num_t                  csr_num,
   input  logic                      csr_we,
   input  logic [31:0]               csr_wmask,
   input  logic [31:0]               csr_wvalue,
   input  logic [31:0]               crmd_word,
   input  logic [31:0]               prmd_word,
   input  logic [31:0]               era_word,
   input  logic [31:0]               badv_word,
   input  logic [31:0]               eentry_word,
   input  logic [12:0]               estat_is,
   input  ecode_t                    estat_ecode,
   input  esubcode_t                 estat_esubcode,
   input  logic [31:0]               ecfg_word,
   input  logic [31:0]               tcfg_word,
   input  logic [31:0]               tval_word,
   input  logic [NUM_SAVE-1:0][31:0] save_words,
   input  logic [31:0]               tid_word,
   output logic [31:0]               csr_rvalue,
   output csr_word_t                 wword,
   output logic                      we_crmd,
   output logic                      we_prmd,
   output logic                      we_ecfg,
   output logic                      we_estat,
   output logic                      we_era,
   output logic                      we_eentry,
   output logic                      we_tcfg,
   output logic                      we_ticlr,
   output logic [NUM_SAVE-1:0]       we_save,
   output logic                      we_tid
);

   logic [31:0]         estat_word;
   logic [31:0]         rd_word;
   logic [NUM_SAVE-1:0] save_hit;

   assign estat_word = {1'b0, estat_esubcode, estat_ecode, 3'b000, estat_is};

   for (genvar i = 0; i < NUM_SAVE; i++) begin : g_save_hit
      assign save_hit[i] = (csr_num == CSR_SAVE0 + csr_num_t'(i));
   end

   // Read mux, unknown numbers and TICLR return zero
   always_comb begin
      case (csr_num)
         CSR_CRMD:   rd_word = crmd_word;
         CSR_PRMD:   rd_word = prmd_word;
         CSR_ECFG:   rd_word = ecfg_word;
         CSR_ESTAT:  rd_word = estat_word;
         CSR_ERA:    rd_word = era_word;
         CSR_BADV:   rd_word = badv_word;
         CSR_EENTRY: rd_word = eentry_word;
         CSR_TID:    rd_word = tid_word;
         CSR_TCFG:   rd_word = tcfg_word;
         CSR_TVAL:   rd_word = tval_word;
         CSR_TICLR:  rd_word = '0;
         default:    rd_word = '0;
      endcase
      for (int i = 0; i < NUM_SAVE; i++) begin
         if (save_hit[i]) begin
            rd_word = save_words[i];
         end
      end
   end

   assign csr_rvalue = rd_word;

   // Bits outside the mask keep the current register contents
   assign wword.raw = (csr_wmask & csr_wvalue) | (~csr_wmask & rd_word);

   assign we_crmd   = csr_we && (csr_num == CSR_CRMD);
   assign we_prmd   = csr_we && (csr_num == CSR_PRMD);
   assign we_ecfg   = csr_we && (csr_num == CSR_ECFG);
   assign we_estat  = csr_we && (csr_num == CSR_ESTAT);
   assign we_era    = csr_we && (csr_num == CSR_ERA);
   assign we_eentry = csr_we && (csr_num == CSR_EENTRY);
   assign we_tcfg   = csr_we && (csr_num == CSR_TCFG);
   assign we_ticlr  = csr_we && (csr_num == CSR_TICLR);
   assign we_tid    = csr_we && (csr_num == CSR_TID);
   assign we_save   = {NUM_SAVE{csr_we}} & save_hit;

endmodule

// ==== design/csr_exc_state.sv ====
`timescale 1ns/10ps

module csr_exc_state import csr_pkg::*; (
   input  logic        clk,
   input  logic        resetn,
   input  csr_word_t   wword,
   input  logic        we_crmd,
   input  logic        we_prmd,
   input  logic        we_era,
   input  logic        we_eentry,
   input  logic        wb_ex,
   input  logic [31:0] wb_pc,
   input  logic [31:0] wb_vaddr,
   input  ecode_t      wb_ecode,
   input  esubcode_t   wb_esubcode,
   input  logic        ertn_flush,
   output logic [31:0] crmd_word,
   output logic [31:0] prmd_word,
   output logic [31:0] era_word,
   output logic [31:0] badv_word,
   output logic [31:0] eentry_word,
   output ecode_t      estat_ecode,
   output esubcode_t   estat_esubcode,
   output logic        crmd_ie,
   output logic [31:0] ex_entry,
   output logic [31:0] era
);

   logic [1:0]  plv_q;
   logic        ie_q;
   logic        da_q;
   logic        pg_q;
   logic [1:0]  datf_q;
   logic [1:0]  datm_q;
   logic [1:0]  pplv_q;
   logic        pie_q;
   logic [31:0] era_q;
   logic [31:0] badv_q;
   logic [25:0] eentry_q;
   logic        addr_err;

   // Exception entry beats ertn, which beats a software write
   always_ff @(posedge clk) begin
      if (!resetn) begin
         {datm_q, datf_q, pg_q, da_q, ie_q, plv_q} <= CRMD_RESET[8:0];
      end else if (wb_ex) begin
         plv_q <= 2'b00;
         ie_q  <= 1'b0;
      end else if (ertn_flush) begin
         plv_q <= pplv_q;
         ie_q  <= pie_q;
      end else if (we_crmd) begin
         plv_q  <= wword.crmd.plv;
         ie_q   <= wword.crmd.ie;
         da_q   <= wword.crmd.da;
         pg_q   <= wword.crmd.pg;
         datf_q <= wword.crmd.datf;
         datm_q <= wword.crmd.datm;
      end
   end

   always_ff @(posedge clk) begin
      if (wb_ex) begin
         pplv_q <= plv_q;
         pie_q  <= ie_q;
      end else if (we_prmd) begin
         pplv_q <= wword.prmd.pplv;
         pie_q  <= wword.prmd.pie;
      end
   end

   always_ff @(posedge clk) begin
      if (wb_ex) begin
         era_q <= wb_pc;
      end else if (we_era) begin
         era_q <= wword.raw;
      end
   end

   assign addr_err = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);

   // Cause fields and bad address
   always_ff @(posedge clk) begin
      if (wb_ex) begin
         estat_ecode    <= wb_ecode;
         estat_esubcode <= wb_esubcode;
      end
      if (wb_ex && addr_err) begin
         // Fetch fault reports the PC itself
         if (wb_ecode == ECODE_ADE && wb_esubcode == ESUB_ADEF) begin
            badv_q <= wb_pc;
         end else begin
            badv_q <= wb_vaddr;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (we_eentry) begin
         eentry_q <= wword.raw[31:6];
      end
   end

   assign crmd_word   = {23'd0, datm_q, datf_q, pg_q, da_q, ie_q, plv_q};
   assign prmd_word   = {29'd0, pie_q, pplv_q};
   assign era_word    = era_q;
   assign badv_word   = badv_q;
   assign eentry_word = {eentry_q, 6'd0};
   assign crmd_ie     = ie_q;
   assign ex_entry    = eentry_word;
   assign era         = era_q;

endmodule

// ==== design/csr_int_status.sv ====
`timescale 1ns/10ps

module csr_int_status import csr_pkg::*; (
   input  logic        clk,
   input  logic        resetn,
   input  csr_word_t   wword,
   input  logic        we_ecfg,
   input  logic        we_estat,
   input  logic        we_ticlr,
   input  logic [7:0]  hw_int,
   input  logic        ipi_int,
   input  logic        timer_zero,
   input  logic        crmd_ie,
   output logic [31:0] ecfg_word,
   output logic [12:0] estat_is,
   output logic        has_int
);

   logic [12:0] lie_q;
   logic [1:0]  sw_is_q;
   logic        ti_q;
   logic [7:0]  hw_is_q;
   logic        ipi_q;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         lie_q   <= '0;
         sw_is_q <= 2'b00;
         ti_q    <= 1'b0;
      end else begin
         if (we_ecfg) begin
            lie_q <= wword.raw[12:0] & ECFG_LIE_MASK;
         end
         if (we_estat) begin
            sw_is_q <= wword.estat.is[1:0];
         end
         // Timer pending holds until software clears it
         if (timer_zero) begin
            ti_q <= 1'b1;
         end else if (we_ticlr && wword.raw[0]) begin
            ti_q <= 1'b0;
         end
      end
   end

   // Level inputs, sampled every cycle
   always_ff @(posedge clk) begin
      hw_is_q <= hw_int;
      ipi_q   <= ipi_int;
   end

   assign estat_is  = {ipi_q, ti_q, 1'b0, hw_is_q, sw_is_q};
   assign ecfg_word = {19'd0, lie_q};
   assign has_int   = (|(estat_is & lie_q)) && crmd_ie;

endmodule

// ==== design/csr_timer.sv ====
`timescale 1ns/10ps

module csr_timer import csr_pkg::*; (
   input  logic        clk,
   input  logic        resetn,
   input  csr_word_t   wword,
   input  logic        we_tcfg,
   output logic [31:0] tcfg_word,
   output logic [31:0] tval_word,
   output logic        timer_zero
);

   logic        en_q;
   logic        periodic_q;
   logic [29:0] initval_q;
   logic [31:0] tval_q;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         en_q <= 1'b0;
      end else if (we_tcfg) begin
         en_q <= wword.tcfg.en;
      end
   end

   always_ff @(posedge clk) begin
      if (we_tcfg) begin
         periodic_q <= wword.tcfg.periodic;
         initval_q  <= wword.tcfg.initval;
      end
   end

   // Down counter, parked at TIMER_IDLE once a one-shot run ends
   always_ff @(posedge clk) begin
      if (!resetn) begin
         tval_q <= TIMER_IDLE;
      end else if (we_tcfg && wword.tcfg.en) begin
         tval_q <= {wword.tcfg.initval, 2'b00};
      end else if (en_q && tval_q != TIMER_IDLE) begin
         if (tval_q == '0) begin
            tval_q <= periodic_q ? {initval_q, 2'b00} : TIMER_IDLE;
         end else begin
            tval_q <= tval_q - 32'd1;
         end
      end
   end

   assign tcfg_word  = {initval_q, periodic_q, en_q};
   assign tval_word  = tval_q;
   assign timer_zero = (tval_q == '0);

endmodule

// ==== design/csr_scratch.sv ====
`timescale 1ns/10ps

module csr_scratch import csr_pkg::*; #(
   parameter int NUM_SAVE = 4
) (
   input  logic                      clk,
   input  logic                      resetn,
   input  csr_word_t                 wword,
   input  logic [NUM_SAVE-1:0]       we_save,
   input  logic                      we_tid,
   input  logic [31:0]               coreid,
   output logic [NUM_SAVE-1:0][31:0] save_words,
   output logic [31:0]               tid_word
);

   // Scratch words for the exception handler
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_SAVE; i++) begin
         if (we_save[i]) begin
            save_words[i] <= wword.raw;
         end
      end
   end

   // TID starts as the core id
   always_ff @(posedge clk) begin
      if (!resetn) begin
         tid_word <= coreid;
      end else if (we_tid) begin
         tid_word <= wword.raw;
      end
   end

endmodule

// ==== design/csr_top.sv ====
`timescale 1ns/10ps

module csr_top import csr_pkg::*; #(
   parameter int NUM_SAVE = 4
) (
   input  logic        clk,
   input  logic        resetn,
   input  csr_num_t    csr_num,
   input  logic        csr_we,
   input  logic [31:0] csr_wmask,
   input  logic [31:0] csr_wvalue,
   output logic [31:0] csr_rvalue,
   input  logic [7:0]  hw_int,
   input  logic        ipi_int,
   input  logic [31:0] coreid,
   input  logic        ertn_flush,
   input  logic        wb_ex,
   input  logic [31:0] wb_pc,
   input  logic [31:0] wb_vaddr,
   input  ecode_t      wb_ecode,
   input  esubcode_t   wb_esubcode,
   output logic [31:0] ex_entry,
   output logic [31:0] era,
   output logic        has_int
);

   csr_word_t wword;

   logic we_crmd;
   logic we_prmd;
   logic we_ecfg;
   logic we_estat;
   logic we_era;
   logic we_eentry;
   logic we_tcfg;
   logic we_ticlr;
   logic we_tid;
   logic [NUM_SAVE-1:0] we_save;

   logic [31:0] crmd_word;
   logic [31:0] prmd_word;
   logic [31:0] era_word;
   logic [31:0] badv_word;
   logic [31:0] eentry_word;
   logic [31:0] ecfg_word;
   logic [31:0] tcfg_word;
   logic [31:0] tval_word;
   logic [31:0] tid_word;
   logic [NUM_SAVE-1:0][31:0] save_words;
   logic [12:0] estat_is;
   ecode_t      estat_ecode;
   esubcode_t   estat_esubcode;
   logic        crmd_ie;
   logic        timer_zero;

   csr_access_ctrl #(
      .NUM_SAVE (NUM_SAVE)
   ) csr_access_ctrl_inst (
      .csr_num        (csr_num),
      .csr_we         (csr_we),
      .csr_wmask      (csr_wmask),
      .csr_wvalue     (csr_wvalue),
      .crmd_word      (crmd_word),
      .prmd_word      (prmd_word),
      .era_word       (era_word),
      .badv_word      (badv_word),
      .eentry_word    (eentry_word),
      .estat_is       (estat_is),
      .estat_ecode    (estat_ecode),
      .estat_esubcode (estat_esubcode),
      .ecfg_word      (ecfg_word),
      .tcfg_word      (tcfg_word),
      .tval_word      (tval_word),
      .save_words     (save_words),
      .tid_word       (tid_word),
      .csr_rvalue     (csr_rvalue),
      .wword          (wword),
      .we_crmd        (we_crmd),
      .we_prmd        (we_prmd),
      .we_ecfg        (we_ecfg),
      .we_estat       (we_estat),
      .we_era         (we_era),
      .we_eentry      (we_eentry),
      .we_tcfg        (we_tcfg),
      .we_ticlr       (we_ticlr),
      .we_save        (we_save),
      .we_tid         (we_tid)
   );

   csr_exc_state csr_exc_state_inst (
      .clk            (clk),
      .resetn         (resetn),
      .wword          (wword),
      .we_crmd        (we_crmd),
      .we_prmd        (we_prmd),
      .we_era         (we_era),
      .we_eentry      (we_eentry),
      .wb_ex          (wb_ex),
      .wb_pc          (wb_pc),
      .wb_vaddr       (wb_vaddr),
      .wb_ecode       (wb_ecode),
      .wb_esubcode    (wb_esubcode),
      .ertn_flush     (ertn_flush),
      .crmd_word      (crmd_word),
      .prmd_word      (prmd_word),
      .era_word       (era_word),
      .badv_word      (badv_word),
      .eentry_word    (eentry_word),
      .estat_ecode    (estat_ecode),
      .estat_esubcode (estat_esubcode),
      .crmd_ie        (crmd_ie),
      .ex_entry       (ex_entry),
      .era            (era)
   );

   csr_int_status csr_int_status_inst (
      .clk        (clk),
      .resetn     (resetn),
      .wword      (wword),
      .we_ecfg    (we_ecfg),
      .we_estat   (we_estat),
      .we_ticlr   (we_ticlr),
      .hw_int     (hw_int),
      .ipi_int    (ipi_int),
      .timer_zero (timer_zero),
      .crmd_ie    (crmd_ie),
      .ecfg_word  (ecfg_word),
      .estat_is   (estat_is),
      .has_int    (has_int)
   );

   csr_timer csr_timer_inst (
      .clk        (clk),
      .resetn     (resetn),
      .wword      (wword),
      .we_tcfg    (we_tcfg),
      .tcfg_word  (tcfg_word),
      .tval_word  (tval_word),
      .timer_zero (timer_zero)
   );

   csr_scratch #(
      .NUM_SAVE (NUM_SAVE)
   ) csr_scratch_inst (
      .clk        (clk),
      .resetn     (resetn),
      .wword      (wword),
      .we_save    (we_save),
      .we_tid     (we_tid),
      .coreid     (coreid),
      .save_words (save_words),
      .tid_word   (tid_word)
   );

endmodule

// ==== tests/csr_tb.sv ====
`timescale 1ns/10ps

module csr_tb import csr_pkg::*; ();

   localparam int          WAIT_LIMIT = 200;
   localparam logic [31:0] CORE_ID    = 32'h0000_0005;

   logic        clk;
   logic        resetn;
   csr_num_t    csr_num;
   logic        csr_we;
   logic [31:0] csr_wmask;
   logic [31:0] csr_wvalue;
   logic [31:0] csr_rvalue;
   logic [7:0]  hw_int;
   logic        ipi_int;
   logic [31:0] coreid;
   logic        ertn_flush;
   logic        wb_ex;
   logic [31:0] wb_pc;
   logic [31:0] wb_vaddr;
   ecode_t      wb_ecode;
   esubcode_t   wb_esubcode;
   logic [31:0] ex_entry;
   logic [31:0] era;
   logic        has_int;

   logic [31:0] lfsr;
   logic [31:0] rdata;
   logic [31:0] era_seen;
   logic [31:0] entry_seen;
   logic        int_seen;

   // Registers covered by the masked write test
   csr_num_t    rw_num [8];
   logic [31:0] rw_bits [8];
   logic [31:0] rw_model [8];
   string       rw_name [8];

   csr_top #(
      .NUM_SAVE (4)
   ) csr_top_inst (
      .clk         (clk),
      .resetn      (resetn),
      .csr_num     (csr_num),
      .csr_we      (csr_we),
      .csr_wmask   (csr_wmask),
      .csr_wvalue  (csr_wvalue),
      .csr_rvalue  (csr_rvalue),
      .hw_int      (hw_int),
      .ipi_int     (ipi_int),
      .coreid      (coreid),
      .ertn_flush  (ertn_flush),
      .wb_ex       (wb_ex),
      .wb_pc       (wb_pc),
      .wb_vaddr    (wb_vaddr),
      .wb_ecode    (wb_ecode),
      .wb_esubcode (wb_esubcode),
      .ex_entry    (ex_entry),
      .era         (era),
      .has_int     (has_int)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         abort_run("a register value did not match the model");
      end
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
   endfunction

   task automatic rand_word(output logic [31:0] word);
      for (int b = 0; b < 32; b++) begin
         lfsr = lfsr_next(lfsr);
         word = {word[30:0], lfsr[0]};
      end
   endtask

   // All bus tasks start and end just after a rising edge
   task automatic write_csr(input csr_num_t num, input logic [31:0] mask,
                            input logic [31:0] value);
      csr_num    <= num;
      csr_we     <= 1'b1;
      csr_wmask  <= mask;
      csr_wvalue <= value;
      @(posedge clk);
      csr_we     <= 1'b0;
   endtask

   task automatic read_csr(input csr_num_t num, output logic [31:0] value);
      csr_num <= num;
      csr_we  <= 1'b0;
      @(negedge clk);
      value = csr_rvalue;
      @(posedge clk);
   endtask

   task automatic sample_outputs();
      @(negedge clk);
      era_seen   = era;
      entry_seen = ex_entry;
      int_seen   = has_int;
      @(posedge clk);
   endtask

   task automatic wait_has_int(input logic want);
      int n;
      n = 0;
      @(negedge clk);
      while (has_int !== want) begin
         if (n == WAIT_LIMIT) begin
            abort_run("has_int did not reach the expected level in time");
         end
         n++;
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   task automatic wait_timer_pending();
      int n;
      n = 0;
      csr_num <= CSR_ESTAT;
      csr_we  <= 1'b0;
      @(negedge clk);
      while (csr_rvalue[11] !== 1'b1) begin
         if (n == WAIT_LIMIT) begin
            abort_run("timer interrupt bit in ESTAT was never set");
         end
         n++;
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   // Follows TVAL down to zero and rejects any upward step
   task automatic watch_countdown();
      logic [31:0] prev;
      logic [31:0] now;
      int          n;
      prev = TIMER_IDLE;
      n    = 0;
      csr_num <= CSR_TVAL;
      csr_we  <= 1'b0;
      @(negedge clk);
      now = csr_rvalue;
      while (now !== 32'd0) begin
         assert (now <= prev) else abort_run("TVAL increased while counting down");
         if (n == WAIT_LIMIT) begin
            abort_run("TVAL did not reach zero in time");
         end
         prev = now;
         n++;
         @(negedge clk);
         now = csr_rvalue;
      end
      @(posedge clk);
   endtask

   task automatic commit_exception(input ecode_t code, input esubcode_t sub,
                                   input logic [31:0] pc, input logic [31:0] vaddr);
      wb_ex       <= 1'b1;
      wb_ecode    <= code;
      wb_esubcode <= sub;
      wb_pc       <= pc;
      wb_vaddr    <= vaddr;
      @(posedge clk);
      wb_ex       <= 1'b0;
   endtask

   initial begin
      logic [31:0] mask;
      logic [31:0] value;
      logic [31:0] prmd_val;

      lfsr        = 32'h63ed_7078;
      resetn      <= 1'b0;
      csr_num     <= CSR_CRMD;
      csr_we      <= 1'b0;
      csr_wmask   <= '0;
      csr_wvalue  <= '0;
      hw_int      <= '0;
      ipi_int     <= 1'b0;
      coreid      <= CORE_ID;
      ertn_flush  <= 1'b0;
      wb_ex       <= 1'b0;
      wb_pc       <= '0;
      wb_vaddr    <= '0;
      wb_ecode    <= '0;
      wb_esubcode <= '0;
      repeat (10) @(posedge clk);
      resetn <= 1'b1;

      read_csr(CSR_CRMD, rdata);
      check("reset CRMD", 32'h0000_0008, rdata);
      read_csr(CSR_ECFG, rdata);
      check("reset ECFG", 32'h0, rdata);
      read_csr(CSR_TVAL, rdata);
      check("reset TVAL", TIMER_IDLE, rdata);
      read_csr(CSR_TID, rdata);
      check("reset TID", CORE_ID, rdata);
      sample_outputs();
      check("reset has_int", 32'h0, {31'd0, int_seen});

      for (int i = 0; i < 4; i++) begin
         rw_num[i]  = CSR_SAVE0 + csr_num_t'(i);
         rw_bits[i] = 32'hffff_ffff;
         rw_name[i] = $sformatf("SAVE%0d", i);
      end
      rw_num[4]  = CSR_ERA;
      rw_bits[4] = 32'hffff_ffff;
      rw_name[4] = "ERA";
      rw_num[5]  = CSR_EENTRY;
      rw_bits[5] = 32'hffff_ffc0;
      rw_name[5] = "EENTRY";
      rw_num[6]  = CSR_PRMD;
      rw_bits[6] = 32'h0000_0007;
      rw_name[6] = "PRMD";
      rw_num[7]  = CSR_ECFG;
      rw_bits[7] = {19'd0, ECFG_LIE_MASK};
      rw_name[7] = "ECFG";

      // First round writes every bit so the model starts from a known value
      for (int r = 0; r < 7; r++) begin
         for (int i = 0; i < 8; i++) begin
            if (r == 0) begin
               mask = 32'hffff_ffff;
            end else begin
               rand_word(mask);
            end
            rand_word(value);
            write_csr(rw_num[i], mask, value);
            rw_model[i] = ((rw_model[i] & ~mask) | (value & mask)) & rw_bits[i];
            read_csr(rw_num[i], rdata);
            check(rw_name[i], rw_model[i], rdata);
         end
      end

      // Exception commit wins over a CRMD write in the same cycle
      write_csr(CSR_CRMD, 32'hffff_ffff, 32'h0000_000f);
      read_csr(CSR_CRMD, rdata);
      check("CRMD before exception", 32'h0000_000f, rdata);
      csr_num    <= CSR_CRMD;
      csr_we     <= 1'b1;
      csr_wmask  <= 32'hffff_ffff;
      csr_wvalue <= 32'h0000_0007;
      commit_exception(ECODE_ALE, 9'h015, 32'h1c00_1234, 32'h0000_8003);
      csr_we     <= 1'b0;
      read_csr(CSR_PRMD, rdata);
      check("PRMD after exception", 32'h0000_0007, rdata);
      read_csr(CSR_CRMD, rdata);
      check("CRMD after exception", 32'h0000_0008, rdata);
      read_csr(CSR_ERA, rdata);
      check("ERA after exception", 32'h1c00_1234, rdata);
      read_csr(CSR_ESTAT, rdata);
      check("ESTAT.ecode ALE", {26'd0, ECODE_ALE}, {26'd0, rdata[21:16]});
      check("ESTAT.esubcode ALE", 32'h0000_0015, {23'd0, rdata[30:22]});
      read_csr(CSR_BADV, rdata);
      check("BADV after ALE", 32'h0000_8003, rdata);
      sample_outputs();
      check("era output", 32'h1c00_1234, era_seen);
      check("ex_entry output", rw_model[5], entry_seen);

      commit_exception(ECODE_ADE, ESUB_ADEF, 32'h1c00_2000, 32'h0bad_0000);
      read_csr(CSR_BADV, rdata);
      check("BADV after ADEF", 32'h1c00_2000, rdata);
      read_csr(CSR_ESTAT, rdata);
      check("ESTAT.ecode ADE", {26'd0, ECODE_ADE}, {26'd0, rdata[21:16]});

      // Return restores plv and ie from PRMD
      prmd_val = 32'h0000_0005;
      write_csr(CSR_PRMD, 32'hffff_ffff, prmd_val);
      ertn_flush <= 1'b1;
      @(posedge clk);
      ertn_flush <= 1'b0;
      read_csr(CSR_CRMD, rdata);
      check("CRMD after ertn", 32'h0000_0008 | (prmd_val & 32'h7), rdata);

      // Hardware line 1 maps to IS bit 3
      write_csr(CSR_ECFG, 32'hffff_ffff, 32'h0000_0008);
      hw_int <= 8'h02;
      wait_has_int(1'b1);
      read_csr(CSR_ESTAT, rdata);
      check("ESTAT.IS hardware line", 32'h0000_0008, rdata & 32'h0000_1fff);
      write_csr(CSR_CRMD, 32'h0000_0004, 32'h0);
      wait_has_int(1'b0);
      write_csr(CSR_CRMD, 32'h0000_0004, 32'h0000_0004);
      wait_has_int(1'b1);
      write_csr(CSR_ECFG, 32'hffff_ffff, 32'h0);
      wait_has_int(1'b0);
      hw_int <= 8'h00;

      write_csr(CSR_ECFG, 32'hffff_ffff, 32'h0000_0001);
      write_csr(CSR_ESTAT, 32'h0000_0003, 32'h0000_0001);
      wait_has_int(1'b1);
      read_csr(CSR_ESTAT, rdata);
      check("ESTAT.IS software bit", 32'h0000_0001, rdata & 32'h0000_1fff);
      write_csr(CSR_ESTAT, 32'h0000_0003, 32'h0);
      wait_has_int(1'b0);
      write_csr(CSR_ECFG, 32'hffff_ffff, 32'h0);

      // One-shot timer with initval 5
      write_csr(CSR_TCFG, 32'hffff_ffff, (32'd5 << 2) | 32'h1);
      read_csr(CSR_TVAL, rdata);
      check("TVAL one-shot load", 32'd20, rdata);
      watch_countdown();
      read_csr(CSR_TVAL, rdata);
      check("TVAL one-shot end", TIMER_IDLE, rdata);
      wait_timer_pending();
      write_csr(CSR_TICLR, 32'hffff_ffff, 32'h0000_0001);
      read_csr(CSR_ESTAT, rdata);
      check("ESTAT.TI after TICLR", 32'h0, rdata & 32'h0000_0800);
      read_csr(CSR_TVAL, rdata);
      check("TVAL stays idle", TIMER_IDLE, rdata);

      // Periodic timer with initval 3
      write_csr(CSR_TCFG, 32'hffff_ffff, (32'd3 << 2) | 32'h3);
      read_csr(CSR_TVAL, rdata);
      check("TVAL periodic load", 32'd12, rdata);
      watch_countdown();
      read_csr(CSR_TVAL, rdata);
      check("TVAL periodic reload", 32'd12, rdata);
      wait_timer_pending();
      write_csr(CSR_TCFG, 32'hffff_ffff, 32'h0);
      write_csr(CSR_TICLR, 32'hffff_ffff, 32'h0000_0001);
      read_csr(CSR_ESTAT, rdata);
      check("ESTAT.TI after periodic TICLR", 32'h0, rdata & 32'h0000_0800);

      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== tb.f ====
common/csr_pkg.sv
design/csr_access_ctrl.sv
design/csr_exc_state.sv
design/csr_int_status.sv
design/csr_timer.sv
design/csr_scratch.sv
design/csr_top.sv
tests/csr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
TOP       := csr_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
